// ==== build.f ====
design/jtdsp16_pkg.sv
design/jtdsp16_mem.sv
design/jtdsp16_ctrl.sv
design/jtdsp16_rom_aau.sv
design/jtdsp16_ram_aau.sv
design/jtdsp16.sv
sim/jtdsp16_tb.sv

// ==== design/jtdsp16.sv ====
`timescale 1ns/1ps

module jtdsp16 #(
    parameter int PC_W   = jtdsp16_pkg::PC_W,
    parameter int RAM_AW = jtdsp16_pkg::RAM_AW
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cen,
    // External data in
    input  logic [15:0] ext_data,
    // ROM programming
    input  logic [11:0] prog_addr,
    input  logic [15:0] prog_data,
    input  logic        prog_we,
    // Instruction address
    output logic [15:0] ext_addr,
    // Data out
    output logic [15:0] out_data,
    output logic        out_stb
);

    import jtdsp16_pkg::*;

    // cen divided by two
    logic              cen2;
    // XAAU
    logic              goto_ja;
    logic              call_ja;
    logic              ret;
    logic [PC_W-1:0]   ja;
    logic [PC_W-1:0]   rom_addr;
    logic [PC_W-1:0]   prog_a;
    instr_t            instr;
    // YAAU and RAM
    yaau_cmd_t         ycmd;
    ram_wr_t           ram_wr;
    logic [RAM_AW-1:0] ram_addr;
    logic [15:0]       ram_dout;

    // Zero-extended PC
    assign ext_addr = 16'(rom_addr);
    assign prog_a   = PC_W'(prog_addr);

    jtdsp16_ctrl #(
        .PC_W     ( PC_W     ),
        .RAM_AW   ( RAM_AW   )
    ) u_ctrl (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cen      ( cen      ),
        .instr    ( instr    ),
        .ext_data ( ext_data ),
        .ram_dout ( ram_dout ),
        .ram_addr ( ram_addr ),
        .cen2     ( cen2     ),
        .goto_ja  ( goto_ja  ),
        .call_ja  ( call_ja  ),
        .ret      ( ret      ),
        .ja       ( ja       ),
        .ycmd     ( ycmd     ),
        .ram_wr   ( ram_wr   ),
        .out_data ( out_data ),
        .out_stb  ( out_stb  )
    );

    // ROM address unit - XAAU
    jtdsp16_rom_aau #(
        .PC_W     ( PC_W     )
    ) u_rom_aau (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cen      ( cen2     ),
        .goto_ja  ( goto_ja  ),
        .call_ja  ( call_ja  ),
        .ret      ( ret      ),
        .ja       ( ja       ),
        .rom_addr ( rom_addr )
    );

    // RAM address unit - YAAU
    jtdsp16_ram_aau #(
        .RAM_AW   ( RAM_AW   )
    ) u_ram_aau (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cen      ( cen2     ),
        .cmd      ( ycmd     ),
        .ram_addr ( ram_addr )
    );

    // Program ROM, write port open at any time
    jtdsp16_mem #(
        .word_t   ( instr_t            ),
        .AW       ( PC_W               )
    ) u_rom (
        .clk      ( clk                ),
        .wr_en    ( prog_we            ),
        .wr_addr  ( prog_a             ),
        .wr_data  ( instr_t'(prog_data) ),
        .rd_addr  ( rom_addr           ),
        .rd_data  ( instr              )
    );

    // Data RAM, 2K words by default
    jtdsp16_mem #(
        .word_t   ( logic [15:0] ),
        .AW       ( RAM_AW       )
    ) u_ram (
        .clk      ( clk          ),
        .wr_en    ( ram_wr.we    ),
        .wr_addr  ( ram_wr.addr  ),
        .wr_data  ( ram_wr.data  ),
        .rd_addr  ( ram_addr     ),
        .rd_data  ( ram_dout     )
    );

endmodule

// ==== design/jtdsp16_ctrl.sv ====
`timescale 1ns/1ps

module jtdsp16_ctrl #(
    parameter int PC_W   = jtdsp16_pkg::PC_W,
    parameter int RAM_AW = jtdsp16_pkg::RAM_AW
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cen,
    // Current instruction from ROM
    input  jtdsp16_pkg::instr_t    instr,
    // Data sources
    input  logic [15:0]            ext_data,
    input  logic [15:0]            ram_dout,
    input  logic [RAM_AW-1:0]      ram_addr,
    // Instruction tick
    output logic                   cen2,
    // XAAU controls
    output logic                   goto_ja,
    output logic                   call_ja,
    output logic                   ret,
    output logic [PC_W-1:0]        ja,
    // YAAU command
    output jtdsp16_pkg::yaau_cmd_t ycmd,
    // RAM write port
    output jtdsp16_pkg::ram_wr_t   ram_wr,
    // Output port
    output logic [15:0]            out_data,
    output logic                   out_stb
);

    import jtdsp16_pkg::*;

    logic    phase;
    reg_op_t reg_op;
    logic    ldx_tick;
    logic    sto_tick;
    logic [15:0] out_hold;

    // Divide cen by two
    // First enabled clock after reset is the idle half
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= 1'b0;
        end else if (cen) begin
            phase <= ~phase;
        end
    end

    assign cen2 = cen & phase;

    // Field views of the operand
    assign reg_op = instr.operand.reg_op;
    assign ja     = PC_W'(instr.operand.ja);

    // Decode, strobes only active on the tick
    always_comb begin
        goto_ja    = 1'b0;
        call_ja    = 1'b0;
        ret        = 1'b0;
        ldx_tick   = 1'b0;
        sto_tick   = 1'b0;
        ycmd.load  = 1'b0;
        ycmd.post  = 1'b0;
        // Register select stays live so the RAM address is stable
        ycmd.r_sel = reg_op.r_sel;
        ycmd.inc   = inc_e'(reg_op.imm[1:0]);
        ycmd.imm   = reg_op.imm;
        if (cen2) begin
            case (instr.opcode)
                OP_GOTO:   goto_ja = 1'b1;
                OP_CALL:   call_ja = 1'b1;
                OP_RETURN: ret = 1'b1;
                OP_LDI:    ycmd.load = 1'b1;
                OP_LDX: begin
                    ldx_tick  = 1'b1;
                    ycmd.post = 1'b1;
                end
                OP_STO: begin
                    sto_tick  = 1'b1;
                    ycmd.post = 1'b1;
                end
                // NOP and anything else
                default: ;
            endcase
        end
    end

    // RAM write at the pointer before post-modify
    always_comb begin
        ram_wr.we   = ldx_tick;
        ram_wr.addr = ram_addr;
        ram_wr.data = ext_data;
    end

    // Strobe lasts one clock, even if cen drops right after
    always_ff @(posedge clk) begin
        if (reset) begin
            out_stb <= 1'b0;
        end else begin
            out_stb <= sto_tick;
        end
    end

    // RAM read data lands on the same edge as the strobe
    // Hold it afterwards so out_data stays put
    always_ff @(posedge clk) begin
        if (out_stb) begin
            out_hold <= ram_dout;
        end
    end

    assign out_data = out_stb ? ram_dout : out_hold;

    // Only defined opcodes should ever reach the execute tick
    a_opcode_legal: assert property (
        @(posedge clk) disable iff (reset)
        cen2 |-> instr.opcode inside {OP_NOP, OP_GOTO, OP_CALL, OP_RETURN,
                                      OP_LDI, OP_LDX, OP_STO}
    ) else $error("jtdsp16_ctrl: undefined opcode %h", instr.opcode);

endmodule

// ==== design/jtdsp16_mem.sv ====
`timescale 1ns/1ps

module jtdsp16_mem #(
    parameter type word_t = logic [15:0],
    parameter int  AW     = jtdsp16_pkg::RAM_AW
) (
    input  logic          clk,
    // Write side
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  word_t         wr_data,
    // Read side
    input  logic [AW-1:0] rd_addr,
    output word_t         rd_data
);

    // Storage, no reset
    word_t mem [0:(1<<AW)-1];

    // Write on the edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read every clock
    // Data shows up one clock after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // A write with an undefined address would corrupt the whole array
    a_wr_addr_known: assert property (
        @(posedge clk) wr_en |-> !$isunknown(wr_addr)
    ) else $error("jtdsp16_mem: write with unknown address");

endmodule

// ==== design/jtdsp16_pkg.sv ====
package jtdsp16_pkg;

    // Default widths, overridden from the top level
    localparam int PC_W   = 12;
    localparam int RAM_AW = 11;

    // Instruction opcodes, upper nibble of the word
    typedef enum logic [3:0] {
        OP_NOP    = 4'h0,
        OP_GOTO   = 4'h1,
        // Return address is PC+1
        OP_CALL   = 4'h2,
        OP_RETURN = 4'h3,
        // Register load, r0-r3 or j
        OP_LDI    = 4'h4,
        // ext_data into RAM
        OP_LDX    = 4'h5,
        // RAM onto out_data
        OP_STO    = 4'h6
    } opcode_e;

    // Post-modify select, found in imm[1:0] of LDX/STO
    typedef enum logic [1:0] {
        INC_NONE   = 2'd0,
        INC_PLUS1  = 2'd1,
        INC_MINUS1 = 2'd2,
        // Add step register j
        INC_STEP   = 2'd3
    } inc_e;

    // Register-operand view of the 12-bit field
    typedef struct packed {
        logic [2:0] r_sel;
        logic [8:0] imm;
    } reg_op_t;

    // Operand is either a jump target or a register operand
    typedef union packed {
        logic [11:0] ja;
        reg_op_t     reg_op;
    } operand_u;

    // Full 16-bit instruction word
    typedef struct packed {
        opcode_e  opcode;
        operand_u operand;
    } instr_t;

    // Controller to YAAU, 16 bits
    typedef struct packed {
        logic       load;
        logic       post;
        logic [2:0] r_sel;
        inc_e       inc;
        logic [8:0] imm;
    } yaau_cmd_t;

    // RAM write port, 28 bits
    typedef struct packed {
        logic              we;
        logic [RAM_AW-1:0] addr;
        logic [15:0]       data;
    } ram_wr_t;

endpackage

// ==== design/jtdsp16_ram_aau.sv ====
`timescale 1ns/1ps

module jtdsp16_ram_aau #(
    parameter int RAM_AW = jtdsp16_pkg::RAM_AW
) (
    input  logic                   clk,
    input  logic                   reset,
    // Instruction tick
    input  logic                   cen,
    // Command from the controller
    input  jtdsp16_pkg::yaau_cmd_t cmd,
    // RAM address
    output logic [RAM_AW-1:0]      ram_addr
);

    import jtdsp16_pkg::*;

    // Pointer registers r0-r3
    logic [RAM_AW-1:0] ptr [0:3];
    // Step register
    logic [RAM_AW-1:0] j;
    logic [1:0]        idx;
    logic [RAM_AW-1:0] cur;
    logic [RAM_AW-1:0] step;
    logic [RAM_AW-1:0] ptr_next;

    // Pointer select, j is not addressable here
    assign idx = cmd.r_sel[1:0];
    assign cur = ptr[idx];

    // Increment amount
    always_comb begin
        case (cmd.inc)
            INC_PLUS1:  step = RAM_AW'(1);
            // All ones subtracts one modulo 2**RAM_AW
            INC_MINUS1: step = '1;
            INC_STEP:   step = j;
            default:    step = '0;
        endcase
    end

    // Wraps naturally at RAM_AW bits
    assign ptr_next = cur + step;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                ptr[i] <= '0;
            end
            j <= '0;
        end else if (cen) begin
            if (cmd.load) begin
                // Select 4 is j, 5-7 write nothing
                if (cmd.r_sel == 3'd4) begin
                    j <= RAM_AW'(cmd.imm);
                end else if (!cmd.r_sel[2]) begin
                    ptr[idx] <= RAM_AW'(cmd.imm);
                end
            end else if (cmd.post) begin
                ptr[idx] <= ptr_next;
            end
        end
    end

    // Address before post-modify, used by this instruction
    assign ram_addr = cur;

    // Load and post-modify target the same pointer file
    // the decoder keeps them apart
    a_load_xor_post: assert property (
        @(posedge clk) disable iff (reset)
        !(cmd.load && cmd.post)
    ) else $error("jtdsp16_ram_aau: load and post-modify together");

endmodule

// ==== design/jtdsp16_rom_aau.sv ====
`timescale 1ns/1ps

module jtdsp16_rom_aau #(
    parameter int PC_W = jtdsp16_pkg::PC_W
) (
    input  logic            clk,
    input  logic            reset,
    // Instruction tick
    input  logic            cen,
    // Flow control from the decoder
    input  logic            goto_ja,
    input  logic            call_ja,
    input  logic            ret,
    input  logic [PC_W-1:0] ja,
    // ROM request
    output logic [PC_W-1:0] rom_addr
);

    // Program counter
    logic [PC_W-1:0] pc;
    // Return register, a single level
    logic [PC_W-1:0] pr;
    logic [PC_W-1:0] pc_inc;
    logic [PC_W-1:0] pc_next;

    // Sequential address, wraps at PC_W bits
    assign pc_inc = pc + 1'b1;

    // Next address selection
    always_comb begin
        if (goto_ja || call_ja) begin
            pc_next = ja;
        end else if (ret) begin
            pc_next = pr;
        end else begin
            pc_next = pc_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            pr <= '0;
        end else if (cen) begin
            pc <= pc_next;
            // Call saves the address after itself
            if (call_ja) begin
                pr <= pc_inc;
            end
        end
    end

    // Fetch address straight from the PC
    // ROM read adds its own register
    assign rom_addr = pc;

    // Decoder must never ask for two jumps at once
    a_one_jump: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({goto_ja, call_ja, ret})
    ) else $error("jtdsp16_rom_aau: more than one jump control active");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the jtdsp16 testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module jtdsp16_tb --Mdir obj_dir -o jtdsp16_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/jtdsp16_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== sim/jtdsp16_tb.sv ====
`timescale 1ns/1ps

module jtdsp16_tb;

    import jtdsp16_pkg::*;

    localparam int CLK_PERIOD = 100;
    // Clock count of each test with some slack, start-up reset first
    localparam int TEST_CYCLES = 3 + 40 + 60 + 45 + 65 + 40 + 45;

    logic        clk;
    logic        reset;
    logic        cen;
    logic [15:0] ext_data;
    logic [11:0] prog_addr;
    logic [15:0] prog_data;
    logic        prog_we;
    logic [15:0] ext_addr;
    logic [15:0] out_data;
    logic        out_stb;

    // Program image of the current test
    logic [15:0] prog_words [0:63];
    // Reference model of PC, return register and pointers
    logic [11:0] m_pc;
    logic [11:0] m_pr;
    logic [10:0] m_ptr [0:3];
    logic [10:0] m_j;
    // RAM keeps its contents through reset, model copy too
    logic [15:0] ram_model [int];
    logic [15:0] exp_q [$];
    logic [15:0] got_q [$];
    logic [15:0] lfsr_state = 16'd94;
    int          errors = 0;
    int          checks = 0;

    jtdsp16 #(
        .PC_W      ( 12        ),
        .RAM_AW    ( 11        )
    ) jtdsp16_i (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .ext_data  ( ext_data  ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .ext_addr  ( ext_addr  ),
        .out_data  ( out_data  ),
        .out_stb   ( out_stb   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(4 * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished, %0d errors so far", errors);
        $display("Checks failed");
        $finish;
    end

    // Output capture, mid-cycle where out_data is settled
    always @(negedge clk) begin
        if (out_stb === 1'b1) begin
            got_q.push_back(out_data);
        end
    end

    // Galois LFSR, x^16+x^14+x^13+x^11+1
    function logic next_lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return b;
    endfunction

    function logic [15:0] random_word();
        logic [15:0] w;
        int          i;
        w = '0;
        for (i = 0; i < 16; i++) begin
            w = {w[14:0], next_lfsr_bit()};
        end
        return w;
    endfunction

    // Instruction encoders
    function logic [15:0] ldi_word(input logic [2:0] r, input logic [8:0] imm);
        return {OP_LDI, r, imm};
    endfunction

    function logic [15:0] mem_word(input opcode_e op, input logic [2:0] r, input inc_e inc);
        return {op, r, 7'd0, inc};
    endfunction

    function logic [15:0] jump_word(input opcode_e op, input logic [11:0] target);
        return {op, target};
    endfunction

    // Inputs change a little after the rising edge
    task next_clock();
        @(posedge clk);
        #5;
    endtask

    task blank_program();
        int i;
        for (i = 0; i < 64; i++) begin
            prog_words[i] = {OP_NOP, 12'd0};
        end
    endtask

    // Only called with reset high
    task program_rom(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            prog_addr = 12'(i);
            prog_data = prog_words[i];
            prog_we   = 1'b1;
            next_clock();
        end
        prog_we = 1'b0;
    endtask

    task reset_model();
        int i;
        m_pc = '0;
        m_pr = '0;
        m_j  = '0;
        for (i = 0; i < 4; i++) begin
            m_ptr[i] = '0;
        end
    endtask

    // Reset, load the program, hold reset 3 more clocks, release
    task load_and_start(input int n);
        reset = 1'b1;
        program_rom(n);
        repeat (3) next_clock();
        reset_model();
        exp_q.delete();
        got_q.delete();
        reset = 1'b0;
    endtask

    // One instruction by the opcode rules
    task predict_instruction(input logic [15:0] ext_word);
        logic [15:0] w;
        logic [2:0]  rs;
        logic [8:0]  imm;
        logic [10:0] p;
        logic [10:0] amt;
        logic [11:0] nxt;
        w   = prog_words[m_pc[5:0]];
        rs  = w[11:9];
        imm = w[8:0];
        p   = m_ptr[rs[1:0]];
        nxt = m_pc + 12'd1;
        case (imm[1:0])
            2'd1:    amt = 11'd1;
            2'd2:    amt = 11'h7FF;
            2'd3:    amt = m_j;
            default: amt = 11'd0;
        endcase
        case (w[15:12])
            OP_GOTO: nxt = w[11:0];
            OP_CALL: begin
                m_pr = m_pc + 12'd1;
                nxt  = w[11:0];
            end
            OP_RETURN: nxt = m_pr;
            OP_LDI: begin
                if (rs == 3'd4) begin
                    m_j = {2'b00, imm};
                end else if (rs < 3'd4) begin
                    m_ptr[rs[1:0]] = {2'b00, imm};
                end
            end
            OP_LDX: begin
                ram_model[int'(p)] = ext_word;
                m_ptr[rs[1:0]] = p + amt;
            end
            OP_STO: begin
                if (ram_model.exists(int'(p))) begin
                    exp_q.push_back(ram_model[int'(p)]);
                end else begin
                    errors++;
                    $display("Test program reads RAM address %0d before writing it", p);
                end
                m_ptr[rs[1:0]] = p + amt;
            end
            default: ;
        endcase
        m_pc = nxt;
    endtask

    task wait_tick();
        logic [15:0] prev;
        int          n;
        prev = ext_addr;
        n = 0;
        while (ext_addr === prev && n < 8) begin
            next_clock();
            n++;
        end
        if (ext_addr === prev) begin
            errors++;
            $display("ext_addr stayed at %0d for 8 clocks at %0t", prev, $time);
        end
    endtask

    // Run n ticks, ext_data set up ahead of each LDX
    task run_ticks(input int n);
        logic [15:0] word;
        int          i;
        for (i = 0; i < n; i++) begin
            word = ext_data;
            if (prog_words[m_pc[5:0]][15:12] == OP_LDX) begin
                word = random_word();
                ext_data = word;
            end
            predict_instruction(word);
            wait_tick();
            checks++;
            if (ext_addr !== {4'd0, m_pc}) begin
                errors++;
                $display("[ERROR] %0t: ext_addr %0d, expected %0d", $time, ext_addr, m_pc);
            end
        end
    endtask

    task check_outputs();
        int i;
        // Let the last strobe reach the capture
        next_clock();
        next_clock();
        checks++;
        if (got_q.size() != exp_q.size()) begin
            errors++;
            $display("[ERROR] %0t: %0d output strobes, expected %0d",
                     $time, got_q.size(), exp_q.size());
        end
        for (i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            checks++;
            if (got_q[i] !== exp_q[i]) begin
                errors++;
                $display("[ERROR] %0t: out_data #%0d is %h, expected %h",
                         $time, i, got_q[i], exp_q[i]);
            end
        end
        got_q.delete();
        exp_q.delete();
    endtask

    // Two enabled clocks per address step
    task sequential_fetch();
        int k;
        blank_program();
        prog_words[10] = jump_word(OP_GOTO, 12'd10);
        load_and_start(11);
        for (k = 1; k <= 8; k++) begin
            next_clock();
            checks++;
            if (ext_addr !== 16'(k - 1)) begin
                errors++;
                $display("[ERROR] %0t: ext_addr %0d on idle clock, expected %0d",
                         $time, ext_addr, k - 1);
            end
            next_clock();
            checks++;
            if (ext_addr !== 16'(k)) begin
                errors++;
                $display("[ERROR] %0t: ext_addr %0d on tick, expected %0d", $time, ext_addr, k);
            end
        end
        check_outputs();
    endtask

    task flow_control();
        blank_program();
        prog_words[0]  = jump_word(OP_GOTO, 12'd20);
        prog_words[20] = jump_word(OP_CALL, 12'd40);
        prog_words[40] = jump_word(OP_RETURN, 12'd0);
        prog_words[22] = jump_word(OP_GOTO, 12'd22);
        load_and_start(41);
        run_ticks(4);
        check_outputs();
    endtask

    // Four words in at r0 from 5, read back through r1 from 5
    task ram_copy();
        int i;
        blank_program();
        prog_words[0] = ldi_word(3'd0, 9'd5);
        for (i = 1; i <= 4; i++) begin
            prog_words[i] = mem_word(OP_LDX, 3'd0, INC_PLUS1);
        end
        prog_words[5] = ldi_word(3'd1, 9'd5);
        for (i = 6; i <= 9; i++) begin
            prog_words[i] = mem_word(OP_STO, 3'd1, INC_PLUS1);
        end
        prog_words[10] = jump_word(OP_GOTO, 12'd10);
        load_and_start(11);
        run_ticks(10);
        check_outputs();
    endtask

    // j = 3, pointers wrap through address 2047 both ways
    task post_modify_modes();
        blank_program();
        prog_words[0]  = ldi_word(3'd4, 9'd3);
        prog_words[1]  = ldi_word(3'd0, 9'd0);
        prog_words[2]  = mem_word(OP_LDX, 3'd0, INC_STEP);
        prog_words[3]  = mem_word(OP_LDX, 3'd0, INC_STEP);
        prog_words[4]  = ldi_word(3'd2, 9'd0);
        prog_words[5]  = mem_word(OP_STO, 3'd2, INC_MINUS1);
        prog_words[6]  = mem_word(OP_LDX, 3'd2, INC_STEP);
        prog_words[7]  = mem_word(OP_LDX, 3'd2, INC_STEP);
        prog_words[8]  = ldi_word(3'd3, 9'd3);
        prog_words[9]  = mem_word(OP_STO, 3'd3, INC_MINUS1);
        prog_words[10] = mem_word(OP_STO, 3'd3, INC_NONE);
        prog_words[11] = mem_word(OP_STO, 3'd3, INC_MINUS1);
        prog_words[12] = ldi_word(3'd1, 9'd0);
        prog_words[13] = mem_word(OP_STO, 3'd1, INC_MINUS1);
        prog_words[14] = mem_word(OP_STO, 3'd1, INC_NONE);
        prog_words[15] = jump_word(OP_GOTO, 12'd15);
        load_and_start(16);
        run_ticks(15);
        check_outputs();
    endtask

    task clock_enable_freeze();
        int          k;
        int          seen;
        logic [15:0] frozen;
        blank_program();
        for (k = 0; k < 6; k++) begin
            prog_words[k] = mem_word(OP_STO, 3'd0, INC_NONE);
        end
        prog_words[6] = jump_word(OP_GOTO, 12'd6);
        load_and_start(7);
        run_ticks(2);
        cen = 1'b0;
        // Strobe of the last tick still shows in this clock
        next_clock();
        seen   = got_q.size();
        frozen = ext_addr;
        for (k = 0; k < 8; k++) begin
            next_clock();
            checks++;
            if (ext_addr !== frozen || out_stb !== 1'b0) begin
                errors++;
                $display("[ERROR] %0t: cen low but ext_addr %0d (was %0d), out_stb %b",
                         $time, ext_addr, frozen, out_stb);
            end
        end
        checks++;
        if (got_q.size() != seen) begin
            errors++;
            $display("[ERROR] %0t: strobe seen while cen low", $time);
        end
        cen = 1'b1;
        run_ticks(3);
        check_outputs();
    endtask

    task reset_mid_run();
        int k;
        blank_program();
        prog_words[0] = ldi_word(3'd0, 9'd9);
        prog_words[1] = ldi_word(3'd1, 9'd6);
        prog_words[2] = mem_word(OP_STO, 3'd0, INC_NONE);
        prog_words[3] = jump_word(OP_GOTO, 12'd3);
        load_and_start(4);
        run_ticks(2);
        // The STO at address 2 is next, reset cuts it off
        reset = 1'b1;
        for (k = 0; k < 3; k++) begin
            next_clock();
            checks++;
            if (ext_addr !== 16'd0 || out_stb !== 1'b0) begin
                errors++;
                $display("[ERROR] %0t: in reset ext_addr %0d, out_stb %b",
                         $time, ext_addr, out_stb);
            end
        end
        // Pointers cleared, so both reads hit address 0
        blank_program();
        prog_words[0] = mem_word(OP_STO, 3'd0, INC_NONE);
        prog_words[1] = mem_word(OP_STO, 3'd1, INC_NONE);
        prog_words[2] = jump_word(OP_GOTO, 12'd2);
        load_and_start(3);
        next_clock();
        checks++;
        if (ext_addr !== 16'd0 || out_stb !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t: after reset ext_addr %0d, out_stb %b",
                     $time, ext_addr, out_stb);
        end
        run_ticks(2);
        check_outputs();
    endtask

    initial begin
        reset     = 1'b1;
        cen       = 1'b1;
        ext_data  = '0;
        prog_addr = '0;
        prog_data = '0;
        prog_we   = 1'b0;
        repeat (3) next_clock();
        sequential_fetch();
        flow_control();
        ram_copy();
        post_modify_modes();
        clock_enable_freeze();
        reset_mid_run();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
